//--- hw/ciPkg.sv
`default_nettype none

package ciPkg;

  // ************************************************************
  // word and id types
  // ************************************************************

  // operand and result word
  typedef logic [31:0] wordT;

  // custom instruction number as sent by the requester
  typedef logic [7:0] ciIdT;

  // profiling counter width, same as one result word
  localparam int counterWidth = 32;

  // ************************************************************
  // instruction ids
  // ************************************************************

  localparam ciIdT swapId    = 8'd1;
  localparam ciIdT profileId = 8'hB;
  localparam ciIdT grayId    = 8'hC;

  // ************************************************************
  // decoded request
  // ************************************************************

  // opNone covers every id that has no unit behind it
  typedef enum logic [1:0] {
    opNone,
    opSwap,
    opProfile,
    opGray
  } ciOpE;

  // 66 bits, carried from dispatcher through queue to executor
  typedef struct packed {
    ciOpE op;
    wordT dataA;
    wordT dataB;
  } ciRequestT;

endpackage

`default_nettype wire

//--- hw/ciDispatcher.sv
`timescale 1ns/1ns
`default_nettype none

module ciDispatcher #(
  parameter int queueDepth = 4
) (
  input  wire logic             s_systemClock,
  input  wire logic             s_pllLocked,
  input  wire logic             ciStart,
  input  wire ciPkg::ciIdT      ciN,
  input  wire ciPkg::wordT      ciDataA,
  input  wire ciPkg::wordT      ciDataB,
  input  wire logic             full,
  output logic                  ciReady,
  output logic                  push,
  output ciPkg::ciRequestT      pushData
);

  // ************************************************************
  // post-lock reset sequencer
  // ************************************************************

  logic [4:0] resetCount;
  logic       sequenceDone;
  logic       accept;

  // counts up to 16 after lock, then holds
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= 5'd0;
    end else if (!resetCount[4]) begin
      resetCount <= resetCount + 5'd1;
    end
  end

  assign sequenceDone = resetCount[4];

  // full already keeps one slot free for the registered request
  assign ciReady = sequenceDone & ~full;
  assign accept  = ciStart & ciReady;

  // ************************************************************
  // decode and request register
  // ************************************************************

  ciPkg::ciOpE      decodedOp;
  ciPkg::ciRequestT nextRequest;

  always_comb begin
    case (ciN)
      ciPkg::swapId:    decodedOp = ciPkg::opSwap;
      ciPkg::profileId: decodedOp = ciPkg::opProfile;
      ciPkg::grayId:    decodedOp = ciPkg::opGray;
      // unknown ids still complete, with zero
      default:          decodedOp = ciPkg::opNone;
    endcase
  end

  always_comb begin
    nextRequest.op    = decodedOp;
    nextRequest.dataA = ciDataA;
    nextRequest.dataB = ciDataB;
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      push <= 1'b0;
    end else begin
      push <= accept;
    end
  end

  // payload only, qualified by push
  always_ff @(posedge s_systemClock) begin
    if (accept) begin
      pushData <= nextRequest;
    end
  end

endmodule

`default_nettype wire

//--- hw/ciRequestQueue.sv
`timescale 1ns/1ns
`default_nettype none

module ciRequestQueue #(
  parameter int queueDepth = 4
) (
  input  wire logic              s_systemClock,
  input  wire logic              s_pllLocked,
  input  wire logic              push,
  input  wire ciPkg::ciRequestT  pushData,
  input  wire logic              pop,
  output logic                   full,
  output logic                   notEmpty,
  output ciPkg::ciRequestT       headData
);

  localparam int ptrWidth   = $clog2(queueDepth);
  localparam int countWidth = ptrWidth + 1;

  localparam logic [countWidth-1:0] depthLevel = countWidth'(queueDepth);
  // one entry is kept for the request sitting in the dispatcher
  localparam logic [countWidth-1:0] holdLevel  = countWidth'(queueDepth - 1);

  ciPkg::ciRequestT        storage [queueDepth];
  logic [ptrWidth-1:0]     writePtr;
  logic [ptrWidth-1:0]     readPtr;
  logic [countWidth-1:0]   count;
  logic                    doPush;
  logic                    doPop;

  assign notEmpty = (count != '0);
  assign full     = (count >= holdLevel);
  assign headData = storage[readPtr];

  assign doPop  = pop & notEmpty;
  assign doPush = push & ((count != depthLevel) | doPop);

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
    end else begin
      if (doPush) begin
        writePtr <= writePtr + 1'b1;
      end
      if (doPop) begin
        readPtr <= readPtr + 1'b1;
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (doPush) begin
      storage[writePtr] <= pushData;
    end
  end

endmodule

`default_nettype wire

//--- hw/ciExecutor.sv
`timescale 1ns/1ns
`default_nettype none

module ciExecutor (
  input  wire logic              s_systemClock,
  input  wire logic              s_pllLocked,
  input  wire logic              notEmpty,
  input  wire ciPkg::ciRequestT  headData,
  input  wire logic              cpuStalled,
  input  wire logic              busIdle,
  output logic                   pop,
  output logic                   ciDone,
  output ciPkg::wordT            ciResult
);

  // ************************************************************
  // datapath functions
  // ************************************************************

  // mode 0 reverses the word, mode 1 swaps inside each half
  function automatic ciPkg::wordT swapBytes(input ciPkg::wordT value, input logic halfMode);
    ciPkg::wordT swapped;
    if (halfMode) begin
      swapped = {value[23:16], value[31:24], value[7:0], value[15:8]};
    end else begin
      swapped = {value[7:0], value[15:8], value[23:16], value[31:24]};
    end
    return swapped;
  endfunction

  // rgb565 to 8 bit luma, weights sum to 256
  function automatic ciPkg::wordT grayValue(input logic [15:0] pixel);
    logic [15:0] red;
    logic [15:0] green;
    logic [15:0] blue;
    logic [15:0] weighted;
    red      = {8'd0, pixel[15:11], 3'd0};
    green    = {8'd0, pixel[10:5], 2'd0};
    blue     = {8'd0, pixel[4:0], 3'd0};
    weighted = red * 16'd54 + green * 16'd183 + blue * 16'd19;
    return {24'd0, weighted[15:8]};
  endfunction

  // ************************************************************
  // profiling counters
  // ************************************************************

  // index 0 cycles, 1 stalled cycles, 2 bus-idle cycles
  logic [ciPkg::counterWidth-1:0] profileCounters [3];
  logic [2:0]                     enableMask;
  logic [2:0]                     countCondition;
  logic [2:0]                     clearMask;
  logic                           profileOp;

  assign pop            = notEmpty;
  assign profileOp      = pop & (headData.op == ciPkg::opProfile);
  assign countCondition = {busIdle, cpuStalled, 1'b1};
  assign clearMask      = profileOp ? headData.dataB[10:8] : 3'b000;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enableMask <= 3'b000;
      for (int i = 0; i < 3; i++) begin
        profileCounters[i] <= '0;
      end
    end else begin
      // disable wins over enable when both are set
      if (profileOp) begin
        enableMask <= (enableMask | headData.dataB[2:0]) & ~headData.dataB[6:4];
      end
      for (int i = 0; i < 3; i++) begin
        if (clearMask[i]) begin
          profileCounters[i] <= '0;
        end else if (enableMask[i] && countCondition[i]) begin
          profileCounters[i] <= profileCounters[i] + 1'b1;
        end
      end
    end
  end

  // ************************************************************
  // result select and output register
  // ************************************************************

  ciPkg::wordT opResult;
  ciPkg::wordT profileValue;

  // counter value before this instruction's control
  always_comb begin
    case (headData.dataA[1:0])
      2'd0:    profileValue = profileCounters[0];
      2'd1:    profileValue = profileCounters[1];
      2'd2:    profileValue = profileCounters[2];
      default: profileValue = '0;
    endcase
  end

  always_comb begin
    case (headData.op)
      ciPkg::opSwap:    opResult = swapBytes(headData.dataA, headData.dataB[0]);
      ciPkg::opGray:    opResult = grayValue(headData.dataA[15:0]);
      ciPkg::opProfile: opResult = profileValue;
      default:          opResult = '0;
    endcase
  end

  // result stays zero between done pulses
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= pop;
      ciResult <= pop ? opResult : '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/ciAccelerator.sv
`timescale 1ns/1ns
`default_nettype none

module ciAccelerator #(
  parameter int queueDepth = 4
) (
  input  wire logic         s_systemClock,
  input  wire logic         s_pllLocked,
  input  wire logic         ciStart,
  input  wire ciPkg::ciIdT  ciN,
  input  wire ciPkg::wordT  ciDataA,
  input  wire ciPkg::wordT  ciDataB,
  input  wire logic         cpuStalled,
  input  wire logic         busIdle,
  output logic              ciReady,
  output logic              ciDone,
  output ciPkg::wordT       ciResult
);

  // ************************************************************
  // stage links
  // ************************************************************

  logic             push;
  ciPkg::ciRequestT pushData;
  logic             full;
  logic             notEmpty;
  ciPkg::ciRequestT headData;
  logic             pop;

  ciDispatcher #(
    .queueDepth(queueDepth)
  ) dispatcher (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .full(full),
    .ciReady(ciReady),
    .push(push),
    .pushData(pushData)
  );

  // requests leave in arrival order
  ciRequestQueue #(
    .queueDepth(queueDepth)
  ) requestQueue (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .push(push),
    .pushData(pushData),
    .pop(pop),
    .full(full),
    .notEmpty(notEmpty),
    .headData(headData)
  );

  ciExecutor executor (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .notEmpty(notEmpty),
    .headData(headData),
    .cpuStalled(cpuStalled),
    .busIdle(busIdle),
    .pop(pop),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

endmodule

`default_nettype wire

//--- tests/ciAccelerator_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ciAcceleratorChecker (
  input wire logic        s_systemClock,
  input wire logic        s_pllLocked,
  input wire logic        ciStart,
  input wire logic        ciReady,
  input wire logic        push,
  input wire logic        pop,
  input wire logic        ciDone,
  input wire ciPkg::wordT ciResult
);

  int         assertFailures = 0;
  logic [4:0] lockCycles;

  // clock edges seen since lock, stops at 17
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCycles <= 5'd0;
    end else if (lockCycles != 5'd17) begin
      lockCycles <= lockCycles + 5'd1;
    end
  end

  // ************************************************************
  // reset
  // ************************************************************

  resetQuiet: assert property (@(posedge s_systemClock)
    !s_pllLocked |-> !ciReady && !push && !pop && !ciDone)
    else begin
      $error("outputs active while s_pllLocked is low");
      assertFailures++;
    end

  readyHeldOff: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    lockCycles < 5'd16 |-> !ciReady)
    else begin
      $error("ciReady rose before 16 cycles");
      assertFailures++;
    end

  readyAfterSequence: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    lockCycles == 5'd16 |-> ciReady)
    else begin
      $error("ciReady not high after 16 cycles");
      assertFailures++;
    end

  // ************************************************************
  // request and result protocol
  // ************************************************************

  startOnlyWhenReady: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    ciStart |-> ciReady)
    else begin
      $error("ciStart while ciReady low");
      assertFailures++;
    end

  resultZeroIdle: assert property (@(posedge s_systemClock)
    !ciDone |-> ciResult == '0)
    else begin
      $error("ciResult nonzero without ciDone");
      assertFailures++;
    end

  // a pushed request reaches the head and is taken on the next cycle
  popAfterPush: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    push |=> pop)
    else begin
      $error("pushed request not popped one cycle later");
      assertFailures++;
    end

endmodule

bind ciAccelerator ciAcceleratorChecker protocolCheck (
  .s_systemClock(s_systemClock),
  .s_pllLocked(s_pllLocked),
  .ciStart(ciStart),
  .ciReady(ciReady),
  .push(push),
  .pop(pop),
  .ciDone(ciDone),
  .ciResult(ciResult)
);

`default_nettype wire

//--- tests/ciAcceleratorTb.sv
`timescale 1ns/1ns
`default_nettype none

module ciAcceleratorTb;

  localparam int queueDepth = 4;
  localparam int waitLimit  = 200;

  // exact is low for profile reads, whose value is checked by the test itself
  typedef struct packed {
    logic        exact;
    ciPkg::wordT value;
  } expectT;

  logic        s_systemClock;
  logic        s_pllLocked;
  logic        ciStart;
  ciPkg::ciIdT ciN;
  ciPkg::wordT ciDataA;
  ciPkg::wordT ciDataB;
  logic        cpuStalled;
  logic        busIdle;
  logic        ciReady;
  logic        ciDone;
  ciPkg::wordT ciResult;

  expectT      expectedResults [$];
  expectT      doneEntry;
  ciPkg::wordT lastResult;
  int          errorCount;
  int          testCount;
  int          failedTests;
  int          errorsBefore;

  ciAccelerator #(
    .queueDepth(queueDepth)
  ) DUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .cpuStalled(cpuStalled),
    .busIdle(busIdle),
    .ciReady(ciReady),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  always #4 s_systemClock = ~s_systemClock;

  // ************************************************************
  // reference model
  // ************************************************************

  function automatic ciPkg::wordT swapReference(input ciPkg::wordT value, input ciPkg::wordT mode);
    ciPkg::wordT result;
    for (int i = 0; i < 4; i++) begin
      if (mode[0]) begin
        result[8*i +: 8] = value[8*(i^1) +: 8];
      end else begin
        result[8*i +: 8] = value[8*(3-i) +: 8];
      end
    end
    return result;
  endfunction

  function automatic ciPkg::wordT grayReference(input ciPkg::wordT pixel);
    int red;
    int green;
    int blue;
    int luma;
    red   = int'(pixel[15:11]) << 3;
    green = int'(pixel[10:5]) << 2;
    blue  = int'(pixel[4:0]) << 3;
    luma  = (red * 54 + green * 183 + blue * 19) >> 8;
    return ciPkg::wordT'(luma);
  endfunction

  function automatic int totalErrors();
    return errorCount + DUT.protocolCheck.assertFailures;
  endfunction

  // ************************************************************
  // result monitor
  // ************************************************************

  always @(negedge s_systemClock) begin
    if (s_pllLocked && ciDone) begin
      if (expectedResults.size() == 0) begin
        $display("ciDone came with no request outstanding");
        errorCount++;
      end else begin
        doneEntry  = expectedResults.pop_front();
        lastResult = ciResult;
        if (doneEntry.exact) begin
          assert (ciResult === doneEntry.value) else begin
            $display("[FAIL] ciResult expected %h got %h", doneEntry.value, ciResult);
            errorCount++;
          end
        end
      end
    end
  end

  // ************************************************************
  // stimulus helpers
  // ************************************************************

  task automatic abortRun(input string reason);
    $display("timeout: %s", reason);
    $display("Verification failed");
    $finish;
  endtask

  task automatic awaitReady();
    int waited;
    waited = 0;
    while (!ciReady && waited < waitLimit) begin
      @(negedge s_systemClock);
      waited++;
    end
    if (!ciReady) begin
      abortRun("ciReady stayed low");
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic issueRequest(input ciPkg::ciIdT id, input ciPkg::wordT a, input ciPkg::wordT b,
                              input logic exact, input ciPkg::wordT value);
    expectT entry;
    awaitReady();
    ciStart     = 1'b1;
    ciN         = id;
    ciDataA     = a;
    ciDataB     = b;
    entry.exact = exact;
    entry.value = value;
    expectedResults.push_back(entry);
    @(negedge s_systemClock);
    ciStart = 1'b0;
  endtask

  task automatic drainResults();
    int waited;
    waited = 0;
    while (expectedResults.size() != 0 && waited < waitLimit) begin
      @(posedge s_systemClock);
      waited++;
    end
    if (expectedResults.size() != 0) begin
      abortRun("results did not all come back");
    end
    @(negedge s_systemClock);
  endtask

  task automatic profileAccess(input ciPkg::wordT a, input ciPkg::wordT b,
                               output ciPkg::wordT value);
    issueRequest(ciPkg::profileId, a, b, 1'b0, '0);
    drainResults();
    value = lastResult;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (totalErrors() == errorsBefore) begin
      $display("test %0d %s: ok", testCount, name);
    end else begin
      failedTests++;
      $display("test %0d %s: %0d errors", testCount, name, totalErrors() - errorsBefore);
    end
    errorsBefore = totalErrors();
  endtask

  // ************************************************************
  // tests
  // ************************************************************

  task automatic swapTest();
    ciPkg::wordT a;
    ciPkg::wordT b;
    for (int i = 0; i < 16; i++) begin
      a    = $urandom;
      b    = $urandom;
      b[0] = i[0];
      issueRequest(ciPkg::swapId, a, b, 1'b1, swapReference(a, b));
    end
    drainResults();
  endtask

  task automatic grayTest();
    ciPkg::wordT pixels [$];
    ciPkg::wordT a;
    // black, white, pure red, pure green, pure blue
    pixels = '{32'h0000_0000, 32'h0000_ffff, 32'h0000_f800, 32'h0000_07e0, 32'h0000_001f};
    for (int i = 0; i < 12; i++) begin
      pixels.push_back($urandom);
    end
    foreach (pixels[i]) begin
      a = pixels[i];
      issueRequest(ciPkg::grayId, a, $urandom, 1'b1, grayReference(a));
    end
    drainResults();
  endtask

  task automatic orderingTest();
    ciPkg::wordT a;
    ciPkg::wordT b;
    int          kind;
    for (int i = 0; i < 24; i++) begin
      a    = $urandom;
      b    = $urandom;
      kind = $urandom_range(0, 2);
      if (kind == 0) begin
        issueRequest(ciPkg::swapId, a, b, 1'b1, swapReference(a, b));
      end else if (kind == 1) begin
        issueRequest(ciPkg::grayId, a, b, 1'b1, grayReference(a));
      end else begin
        // ids 16 and up have no unit behind them
        issueRequest(ciPkg::ciIdT'($urandom_range(16, 255)), a, b, 1'b1, '0);
      end
    end
    drainResults();
  endtask

  task automatic profileTest();
    ciPkg::wordT ignored;
    ciPkg::wordT cycles;
    ciPkg::wordT stalls;
    ciPkg::wordT idles;
    ciPkg::wordT firstRead;
    ciPkg::wordT secondRead;
    cpuStalled = 1'b0;
    busIdle    = 1'b1;
    profileAccess(32'd0, 32'h0000_0707, ignored);
    repeat (20) @(negedge s_systemClock);
    // idle first, so it cannot run ahead of the cycle count
    profileAccess(32'd2, 32'd0, idles);
    profileAccess(32'd0, 32'd0, cycles);
    profileAccess(32'd1, 32'd0, stalls);
    assert (stalls == '0) else begin
      $display("[FAIL] ciResult stall count expected 00000000 got %h", stalls);
      errorCount++;
    end
    assert (idles != '0 && idles <= cycles) else begin
      $display("[FAIL] ciResult bus-idle count %h outside 1 to %h", idles, cycles);
      errorCount++;
    end
    // disabled counter holds its value
    profileAccess(32'd0, 32'h0000_0707, ignored);
    repeat (10) @(negedge s_systemClock);
    profileAccess(32'd0, 32'h0000_0070, ignored);
    profileAccess(32'd0, 32'd0, firstRead);
    repeat (10) @(negedge s_systemClock);
    profileAccess(32'd0, 32'd0, secondRead);
    assert (firstRead == secondRead) else begin
      $display("[FAIL] ciResult disabled count expected %h got %h", firstRead, secondRead);
      errorCount++;
    end
    // clear
    profileAccess(32'd0, 32'h0000_0707, ignored);
    repeat (10) @(negedge s_systemClock);
    profileAccess(32'd0, 32'h0000_0770, ignored);
    profileAccess(32'd0, 32'd0, cycles);
    assert (cycles == '0) else begin
      $display("[FAIL] ciResult cleared count expected 00000000 got %h", cycles);
      errorCount++;
    end
    busIdle = 1'b0;
  endtask

  initial begin
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciStart       = 1'b0;
    ciN           = '0;
    ciDataA       = '0;
    ciDataB       = '0;
    cpuStalled    = 1'b0;
    busIdle       = 1'b0;
    errorCount    = 0;
    testCount     = 0;
    failedTests   = 0;
    errorsBefore  = 0;
    void'($urandom(32'h49345ea6));

    repeat (8) @(negedge s_systemClock);
    s_pllLocked = 1'b1;
    awaitReady();
    finishTest("reset");

    swapTest();
    finishTest("swap");
    grayTest();
    finishTest("grayscale");
    orderingTest();
    finishTest("ordering");
    profileTest();
    finishTest("profiling");

    $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, totalErrors());
    if (failedTests == 0 && totalErrors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hw/ciPkg.sv
hw/ciDispatcher.sv
hw/ciRequestQueue.sv
hw/ciExecutor.sv
hw/ciAccelerator.sv
tests/ciAccelerator_checker.sv
tests/ciAcceleratorTb.sv

//--- Makefile
# Verilator build and run for the custom instruction accelerator

TOP := ciAcceleratorTb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f src.f -Mdir obj_dir

# pass or fail comes from the log, not from the exit status of the run
run: build
	-./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Verification passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir $(LOG)
